// ==== hw/fpAdd_params.svh ====
// Field widths and special encodings of IEEE-754 single precision
`ifndef FP_ADD_PARAMS_SVH
`define FP_ADD_PARAMS_SVH

// Exponent field width
`define FP_EXP_W 8

// Stored fraction width without the hidden bit
`define FP_MAN_W 23

// All-ones exponent shared by infinity and NaN
`define FP_EXP_MAX 8'd255

// Canonical NaN for infinity minus infinity
`define FP_QNAN 32'h7FFF_FFFF

`endif

// ==== hw/fpPkg.sv ====
// Shared data types of the single-precision adder datapath
`default_nettype none

`include "fpAdd_params.svh"

package fpPkg;

    // Biased exponent field
    typedef logic [`FP_EXP_W-1:0] fpExp;

    // Mantissa with the hidden bit on top
    typedef logic [`FP_MAN_W:0] fpMan;

    // One packed IEEE-754 word
    typedef struct packed
    {
        logic                   sign;
        fpExp                   exponent;
        logic [`FP_MAN_W-1:0]   mantissa;
    } fpWord;

    // Extra bits below the mantissa LSB
    typedef struct packed
    {
        logic guard;
        logic round;
        logic sticky;   // OR of everything shifted further out
    } grsBits;

endpackage

`default_nettype wire

// ==== hw/fpBus.sv ====
// Bus between the align, add and normalize steps of the FP adder
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_params.svh"

interface fpBus
(
    input logic clk,
    input logic reset,
    input logic inValid
);
    import fpPkg::*;

    // Unpacked operands
    fpWord                  A, B;
    logic                   signA, signB;   // signB is the effective sign
    fpExp                   exponentA, exponentB;
    logic [`FP_MAN_W-1:0]   mantissaA, mantissaB;

    // Alignment results
    fpExp                   exponentOut;
    fpMan                   largeMantissa, smallMantissa;
    logic                   largeSign;
    logic                   effSubtract;
    grsBits                 alignGrs;

    // Sum
    fpMan                   alignedResult;
    logic                   alignedSign;
    logic                   carryOut;
    grsBits                 sumGrs;     // GRS after borrow

    // Final fields
    logic                   normalizedSign;
    fpExp                   normalizedExponent;
    logic [`FP_MAN_W-1:0]   normalizedMantissa;

    modport align (input clk, reset, inValid,
                   output A, B, signA, signB, exponentA, exponentB, mantissaA, mantissaB,
                   output exponentOut, largeMantissa, smallMantissa, largeSign,
                   output effSubtract, alignGrs);

    modport add (input clk, reset, inValid,
                 input largeMantissa, smallMantissa, largeSign, effSubtract, alignGrs,
                 output alignedResult, alignedSign, carryOut, sumGrs);

    modport normal (input clk, reset, inValid,
                    input A, B, signA, signB, exponentA, exponentB, mantissaA, mantissaB,
                    input exponentOut, alignedResult, alignedSign, carryOut, sumGrs,
                    output normalizedSign, normalizedExponent, normalizedMantissa);

endinterface

`default_nettype wire

// ==== hw/Align.sv ====
// Alignment step that orders both operands and shifts the smaller mantissa right
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_params.svh"

module Align
(
    input  fpPkg::fpWord    opA,
    input  fpPkg::fpWord    opB,
    input  logic            subtract,
    fpBus.align             bus
);
    import fpPkg::*;

    localparam int ShiftMax = `FP_MAN_W + 3;    // Beyond this only sticky is left

    fpExp expA, expB;
    fpExp largeExp, smallExp, expDiff;
    fpMan manA, manB, smallMan;
    logic swap;
    logic [4:0] shiftAmount;
    logic [`FP_MAN_W+ShiftMax:0] shiftedWide;

    // Raw fields for the special-value checks downstream
    assign bus.A = opA;
    assign bus.B = opB;
    assign bus.signA = opA.sign;
    assign bus.signB = opB.sign ^ subtract;   // Subtraction flips B
    assign bus.exponentA = opA.exponent;
    assign bus.exponentB = opB.exponent;
    assign bus.mantissaA = opA.mantissa;
    assign bus.mantissaB = opB.mantissa;

    // Zero and subnormal operands act as exponent 1 without a hidden bit
    assign expA = (opA.exponent == '0) ? fpExp'(1) : opA.exponent;
    assign expB = (opB.exponent == '0) ? fpExp'(1) : opB.exponent;
    assign manA = {opA.exponent != '0, opA.mantissa};
    assign manB = {opB.exponent != '0, opB.mantissa};

    // Magnitude order, ties keep A on top
    assign swap = {opB.exponent, opB.mantissa} > {opA.exponent, opA.mantissa};

    assign largeExp = swap ? expB : expA;
    assign smallExp = swap ? expA : expB;
    assign smallMan = swap ? manA : manB;

    assign expDiff = largeExp - smallExp;
    assign shiftAmount = (expDiff > fpExp'(ShiftMax)) ? 5'(ShiftMax) : expDiff[4:0];

    // Bits below the mantissa become guard, round and sticky
    assign shiftedWide = {smallMan, {ShiftMax{1'b0}}} >> shiftAmount;

    assign bus.exponentOut = largeExp;
    assign bus.largeMantissa = swap ? manB : manA;
    assign bus.smallMantissa = shiftedWide[`FP_MAN_W+ShiftMax -: $bits(fpMan)];
    assign bus.largeSign = swap ? bus.signB : bus.signA;
    assign bus.effSubtract = opA.sign ^ opB.sign ^ subtract;

    assign bus.alignGrs = {shiftedWide[ShiftMax-1],
                           shiftedWide[ShiftMax-2],
                           |shiftedWide[ShiftMax-3:0]};

    // Ordering must hold for every strobed operation
    orderedExponents: assert property (@(posedge bus.clk) disable iff (bus.reset)
        bus.inValid |-> largeExp >= smallExp);

endmodule

`default_nettype wire

// ==== hw/MantissaAdd.sv ====
// Signed mantissa adder working on the aligned operands and their GRS bits
`timescale 1ns/1ps
`default_nettype none

module MantissaAdd
(
    fpBus.add bus
);
    import fpPkg::*;

    localparam int GrsW = $bits(grsBits);
    localparam int ExtW = $bits(fpMan) + GrsW;

    logic [ExtW-1:0] largeExt, smallExt;
    logic [ExtW:0]   sum;                   // Top bit is the carry

    always_comb
    begin
        largeExt = {bus.largeMantissa, {GrsW{1'b0}}};
        smallExt = {bus.smallMantissa, bus.alignGrs};

        // GRS sit below the LSB so borrow ripples up through them
        if (bus.effSubtract)
            sum = {1'b0, largeExt} - {1'b0, smallExt};
        else
            sum = {1'b0, largeExt} + {1'b0, smallExt};
    end

    assign bus.carryOut = sum[ExtW];
    assign bus.alignedResult = sum[ExtW-1:GrsW];
    assign bus.sumGrs = sum[GrsW-1:0];

    // Exact cancellation is +0
    assign bus.alignedSign = (bus.effSubtract && sum == '0) ? 1'b0 : bus.largeSign;

    // A set carry here means Align ordered the magnitudes wrong
    noCarryOnSubtract: assert property (@(posedge bus.clk) disable iff (bus.reset)
        bus.inValid && bus.effSubtract |-> !bus.carryOut);

endmodule

`default_nettype wire

// ==== hw/Normalize.sv ====
// Normalize step with special values, renormalization and round-to-nearest-even
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_params.svh"

module Normalize
(
    fpBus.normal bus
);
    import fpPkg::*;

    logic [`FP_MAN_W+3:0]   shifted;        // Mantissa with GRS below
    logic [4:0]             shiftAmount;
    logic [9:0]             expWide;        // Room for overflow and a negative result
    logic [`FP_MAN_W+1:0]   rounded;
    fpMan                   mant;
    grsBits                 grs;
    logic                   roundUp;
    logic                   aNan, bNan, aInf, bInf;

    // Leading zeros of a 24-bit mantissa, 24 when empty
    function automatic logic [4:0] countZeros(input fpMan value);
        logic [4:0] count;
        count = 5'd24;
        for (int i = 0; i <= `FP_MAN_W; i++)
        begin
            if (value[i])
                count = 5'(`FP_MAN_W - i);  // Highest set bit wins
        end
        return count;
    endfunction

    assign aNan = (bus.exponentA == `FP_EXP_MAX) && (bus.mantissaA != '0);
    assign bNan = (bus.exponentB == `FP_EXP_MAX) && (bus.mantissaB != '0);
    assign aInf = (bus.exponentA == `FP_EXP_MAX) && (bus.mantissaA == '0);
    assign bInf = (bus.exponentB == `FP_EXP_MAX) && (bus.mantissaB == '0);

    always_comb
    begin
        shiftAmount = '0;
        shifted = '0;
        expWide = '0;
        mant = '0;
        grs = '0;
        roundUp = 1'b0;
        rounded = '0;
        bus.normalizedSign = bus.alignedSign;
        bus.normalizedExponent = '0;
        bus.normalizedMantissa = '0;

        // NaN and infinity
        if (bus.exponentOut == `FP_EXP_MAX)
        begin
            if (aNan)
                {bus.normalizedSign, bus.normalizedExponent, bus.normalizedMantissa} = bus.A;
            else if (bNan)
                {bus.normalizedSign, bus.normalizedExponent, bus.normalizedMantissa} = bus.B;
            else if (aInf && bInf && (bus.signA != bus.signB))
                {bus.normalizedSign, bus.normalizedExponent, bus.normalizedMantissa} = `FP_QNAN;
            else if (aInf)
                {bus.normalizedSign, bus.normalizedExponent, bus.normalizedMantissa} = bus.A;
            else
            begin
                bus.normalizedSign = bus.signB;     // Effective sign after subtract
                bus.normalizedExponent = bus.exponentB;
                bus.normalizedMantissa = bus.mantissaB;
            end
        end
        else if (bus.alignedResult == '0 && bus.sumGrs == '0 && !bus.carryOut)
        begin
            // Zero sum, sign already resolved by the adder
            bus.normalizedSign = bus.alignedSign;
        end
        else
        begin
            if (bus.carryOut)
            begin
                // Shift right one, the dropped bit becomes guard
                mant = {1'b1, bus.alignedResult[`FP_MAN_W:1]};
                grs.guard = bus.alignedResult[0];
                grs.round = bus.sumGrs.guard;
                grs.sticky = bus.sumGrs.round | bus.sumGrs.sticky;
                expWide = {2'b00, bus.exponentOut} + 10'd1;
            end
            else
            begin
                shiftAmount = countZeros(bus.alignedResult);
                shifted = {bus.alignedResult, bus.sumGrs} << shiftAmount;
                mant = shifted[`FP_MAN_W+3:3];
                grs = shifted[2:0];
                expWide = {2'b00, bus.exponentOut} - {5'b00000, shiftAmount};
            end

            // Nearest-even
            roundUp = grs.guard & (grs.round | grs.sticky | mant[0]);
            rounded = {1'b0, mant} + {{(`FP_MAN_W+1){1'b0}}, roundUp};
            if (rounded[`FP_MAN_W+1])
            begin
                rounded = rounded >> 1;     // All ones rolled over to 10.0
                expWide = expWide + 10'd1;
            end

            if (expWide[9] || expWide == '0)
            begin
                // Flush to signed zero
                bus.normalizedExponent = '0;
                bus.normalizedMantissa = '0;
            end
            else if (expWide >= 10'(`FP_EXP_MAX))
            begin
                bus.normalizedExponent = `FP_EXP_MAX;   // Infinity
                bus.normalizedMantissa = '0;
            end
            else
            begin
                bus.normalizedExponent = expWide[`FP_EXP_W-1:0];
                bus.normalizedMantissa = rounded[`FP_MAN_W-1:0];
            end
        end
    end

    // Finite inputs must never turn into a NaN
    finiteOverflowIsInf: assert property (@(posedge bus.clk) disable iff (bus.reset)
        bus.inValid && (bus.exponentOut != `FP_EXP_MAX)
            && (bus.normalizedExponent == `FP_EXP_MAX)
        |-> bus.normalizedMantissa == '0);

endmodule

`default_nettype wire

// ==== hw/FpAdder.sv ====
// Single-precision FP adder and subtractor with a registered result
`timescale 1ns/1ps
`default_nettype none

module FpAdder
(
    input  logic            clk,
    input  logic            reset,
    input  logic            inValid,
    input  logic            subtract,
    input  fpPkg::fpWord    opA,
    input  fpPkg::fpWord    opB,
    output logic            outValid,
    output fpPkg::fpWord    result
);
    import fpPkg::*;

    fpWord normWord;

    fpBus bus
    (
        .clk(clk),
        .reset(reset),
        .inValid(inValid)
    );

    Align alignStep
    (
        .opA(opA),
        .opB(opB),
        .subtract(subtract),
        .bus(bus.align)
    );

    MantissaAdd addStep
    (
        .bus(bus.add)
    );

    Normalize normalStep
    (
        .bus(bus.normal)
    );

    assign normWord = {bus.normalizedSign, bus.normalizedExponent, bus.normalizedMantissa};

    // One cycle from strobe to result
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outValid <= 1'b0;
            result   <= '0;
        end
        else
        begin
            outValid <= inValid;
            if (inValid)
                result <= normWord;     // Held between strobes
        end
    end

endmodule

`default_nettype wire

// ==== sim/FpAdderTb.sv ====
// Table-driven testbench for the single-precision FP adder and subtractor
`timescale 1ns/1ps
`default_nettype none

module FpAdderTb;
    import fpPkg::*;

    typedef struct packed
    {
        fpWord  a;
        fpWord  b;
        logic   sub;
        fpWord  expected;
    } testEntry;

    logic   clk = 1'b0;
    logic   reset;
    logic   inValid;
    logic   subtract;
    fpWord  opA;
    fpWord  opB;
    logic   outValid;
    fpWord  result;

    testEntry vectors[$];
    fpWord  expWord;                    // Expected word of the entry now on the inputs
    fpWord  expWordPipe;
    logic   expValidPipe = 1'b0;
    int     resultsChecked = 0;
    int     valueErrors = 0;
    int     timeouts = 0;

    FpAdder u_dut
    (
        .clk(clk),
        .reset(reset),
        .inValid(inValid),
        .subtract(subtract),
        .opA(opA),
        .opB(opB),
        .outValid(outValid),
        .result(result)
    );

    always #2 clk = ~clk;

    task automatic checkWord(input fpWord actual, input fpWord expected);
        if (actual !== expected)
        begin
            $display("FAILED at %0t: result got %08h expected %08h", $time, actual, expected);
            valueErrors++;
        end
    endtask

    task automatic checkValid(input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("FAILED at %0t: outValid got %b expected %b", $time, actual, expected);
            valueErrors++;
        end
    endtask

    task automatic checkCycles(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, actual, expected);
            valueErrors++;
        end
    endtask

    task automatic addEntry(input fpWord a, input fpWord b, input logic sub,
                            input fpWord expected);
        vectors.push_back(testEntry'({a, b, sub, expected}));
    endtask

    // Expected words worked out by hand
    task automatic buildTable();
        addEntry(32'h3F80_0000, 32'h3F80_0000, 1'b0, 32'h4000_0000);    // 1 + 1 with carry
        addEntry(32'h4040_0000, 32'h3F80_0000, 1'b1, 32'h4000_0000);    // 3 - 1
        addEntry(32'h3FC0_0000, 32'h3FC0_0000, 1'b0, 32'h4040_0000);
        addEntry(32'h3F80_0000, 32'hBE80_0000, 1'b0, 32'h3F40_0000);    // 1 + -0.25
        addEntry(32'hBF80_0000, 32'h3F80_0000, 1'b1, 32'hC000_0000);
        addEntry(32'h0000_0000, 32'h3F80_0000, 1'b0, 32'h3F80_0000);    // Zero operand
        addEntry(32'h3F80_0000, 32'h3380_0000, 1'b1, 32'h3F7F_FFFF);    // Borrow from guard
        addEntry(32'h3F80_0000, 32'h3F7F_FFFF, 1'b1, 32'h3380_0000);    // Only guard survives
        // Nearest-even
        addEntry(32'h3F80_0000, 32'h3380_0000, 1'b0, 32'h3F80_0000);    // Tie stays even
        addEntry(32'h3F80_0001, 32'h3380_0000, 1'b0, 32'h3F80_0002);    // Tie up to even
        addEntry(32'h3F80_0000, 32'h3380_0001, 1'b0, 32'h3F80_0001);    // Sticky rounds up
        addEntry(32'h3F80_0001, 32'h3F80_0000, 1'b0, 32'h4000_0000);    // Carry, tie down
        addEntry(32'h3F80_0003, 32'h3F80_0000, 1'b0, 32'h4000_0002);    // Carry, tie up
        addEntry(32'h3FFF_FFFF, 32'h3380_0000, 1'b0, 32'h4000_0000);    // Into the exponent
        // NaN and infinity
        addEntry(32'h7FC0_0001, 32'h3F80_0000, 1'b0, 32'h7FC0_0001);
        addEntry(32'h3F80_0000, 32'h7FA0_0000, 1'b0, 32'h7FA0_0000);
        addEntry(32'h7FC0_0001, 32'hFF80_0005, 1'b1, 32'h7FC0_0001);    // A wins over B
        addEntry(32'h7F80_0000, 32'h7F80_0000, 1'b1, 32'h7FFF_FFFF);
        addEntry(32'h7F80_0000, 32'h3F80_0000, 1'b0, 32'h7F80_0000);
        addEntry(32'h3F80_0000, 32'h7F80_0000, 1'b1, 32'hFF80_0000);    // Negated infinity
        addEntry(32'h7F80_0000, 32'h7F80_0000, 1'b0, 32'h7F80_0000);
        // Overflow, cancellation and flush
        addEntry(32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0, 32'h7F80_0000);
        addEntry(32'hFF7F_FFFF, 32'h7F7F_FFFF, 1'b1, 32'hFF80_0000);
        addEntry(32'h3FC0_0000, 32'h3FC0_0000, 1'b1, 32'h0000_0000);
        addEntry(32'h0080_0001, 32'h0080_0000, 1'b1, 32'h0000_0000);
        addEntry(32'h0080_0000, 32'h0080_0001, 1'b1, 32'h8000_0000);    // Signed zero
    endtask

    task automatic applyEntry(input testEntry e);
        @(posedge clk);
        #1;
        opA = e.a;
        opB = e.b;
        subtract = e.sub;
        expWord = e.expected;
        inValid = 1'b1;
    endtask

    task automatic driveIdle();
        @(posedge clk);
        #1;
        inValid = 1'b0;
        subtract = 1'b0;
        opA = '0;
        opB = '0;
    endtask

    // Single strobe, then count edges until the result shows up
    task automatic measureLatency(input testEntry e);
        int cycles;
        applyEntry(e);
        driveIdle();
        cycles = 1;
        while (outValid !== 1'b1 && cycles < 20)
        begin
            driveIdle();
            cycles++;
        end
        if (outValid !== 1'b1)
        begin
            $display("Timeout: outValid did not rise within 20 cycles of a single strobe");
            timeouts++;
        end
        else
            checkCycles("outValid latency", cycles, 1);
    endtask

    task automatic waitForChecks(input int count);
        int cycles;
        cycles = 0;
        while (resultsChecked < count && cycles < 20)
        begin
            @(posedge clk);
            cycles++;
        end
        if (resultsChecked < count)
        begin
            $display("Timeout: only %0d of %0d results arrived", resultsChecked, count);
            timeouts++;
        end
    endtask

    // Reference timing, strobe sampled on one edge gives the result on that edge
    always @(posedge clk)
    begin
        expValidPipe <= !reset && inValid;
        if (!reset && inValid)
            expWordPipe <= expWord;
    end

    always @(negedge clk)
    begin
        checkValid(outValid, expValidPipe);     // Also covers reset and idle cycles
        if (expValidPipe)
        begin
            checkWord(result, expWordPipe);
            resultsChecked++;
        end
    end

    initial
    begin
        reset = 1'b1;
        inValid = 1'b1;                 // Strobe held through reset must be ignored
        subtract = 1'b0;
        opA = 32'h3F80_0000;
        opB = 32'h3F80_0000;
        expWord = '0;
        buildTable();

        repeat (16) @(posedge clk);
        #1;
        checkWord(result, '0);
        reset = 1'b0;
        inValid = 1'b0;
        driveIdle();

        foreach (vectors[i])
            applyEntry(vectors[i]);     // Back to back
        repeat (4) driveIdle();
        measureLatency(vectors[0]);
        waitForChecks(vectors.size() + 1);
        repeat (2) driveIdle();

        $display("Results checked: %0d, value errors: %0d, timeouts: %0d",
                 resultsChecked, valueErrors, timeouts);
        if (valueErrors == 0 && timeouts == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hw
hw/fpPkg.sv
hw/fpBus.sv
hw/Align.sv
hw/MantissaAdd.sv
hw/Normalize.sv
hw/FpAdder.sv
sim/FpAdderTb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the FP adder

VERILATOR  ?= verilator
TOP        ?= FpAdderTb
RTL_TOP    ?= FpAdder
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^PASS: all tests$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
